// ==== hdl/dispatch_pkg.sv ====
// Vector dispatch package with the widths, uop, ROB entry, operand and RS payload types
package dispatch_pkg;

    // Uops examined per cycle and VRF read ports shared by them
    parameter int NUM_DP_UOP = 2;
    parameter int NUM_VRF_RD = 4;
    parameter int VLEN       = 128;
    parameter int ROB_DEPTH  = 8;

    typedef logic [4:0]                   vreg_idx_t;
    typedef logic [VLEN-1:0]              vdata_t;
    typedef logic [$clog2(ROB_DEPTH)-1:0] rob_tag_t;
    typedef logic [5:0]                   funct6_t;
    typedef logic [31:0]                  xdata_t;
    // Number of VRF sources, up to three per uop and six for both
    typedef logic [2:0]                   src_cnt_t;

    typedef enum logic {
        EXE_ALU,
        EXE_MUL
    } exe_unit_e;

    typedef struct packed {
        vreg_idx_t vs1_idx;
        logic      vs1_valid;
        vreg_idx_t vs2_idx;
        logic      vs2_valid;
        vreg_idx_t vd_idx;
        logic      vd_valid;
        // vd is also read as a third source
        logic      vs3_valid;
        exe_unit_e exe_unit;
        funct6_t   funct6;
        xdata_t    rs1_data;
        logic      rs1_valid;
        logic      last_uop;
    } dp_uop_t;

    typedef struct packed {
        logic      valid;
        vreg_idx_t w_idx;
        // Result written back and usable for bypass
        logic      w_valid;
        vdata_t    w_data;
    } rob_entry_t;

    typedef struct packed {
        logic   vs1_hazard;
        logic   vs1_hit;
        vdata_t vs1_data;
        logic   vs2_hazard;
        logic   vs2_hit;
        vdata_t vs2_data;
        logic   vs3_hazard;
        logic   vs3_hit;
        vdata_t vs3_data;
        logic   hazard;
    } raw_info_t;

    typedef struct packed {
        vdata_t vs1;
        vdata_t vs2;
        vdata_t vd;
    } uop_operand_t;

    typedef struct packed {
        rob_tag_t rob_tag;
        funct6_t  funct6;
        vdata_t   vs1_data;
        logic     vs1_valid;
        vdata_t   vs2_data;
        logic     vs2_valid;
        vdata_t   vd_data;
        logic     vd_valid;
        xdata_t   rs1_data;
        logic     rs1_valid;
    } rs_uop_t;

    typedef struct packed {
        vreg_idx_t w_idx;
        logic      w_valid;
        logic      last_uop;
    } rob_push_t;

    // VRF sources read by one uop
    function automatic src_cnt_t src_count(dp_uop_t u);
        return src_cnt_t'(u.vs1_valid) + src_cnt_t'(u.vs2_valid) + src_cnt_t'(u.vs3_valid);
    endfunction

endpackage

// ==== hdl/dispatch_raw_rob.sv ====
// RAW check of one uop against the ROB entries, giving stall and bypass information
`timescale 1ns/1ps

module dispatch_raw_rob #(
    parameter int ROB_DEPTH = dispatch_pkg::ROB_DEPTH
) (
    input  dispatch_pkg::dp_uop_t                    uop,
    input  dispatch_pkg::rob_entry_t [ROB_DEPTH-1:0] rob_entries,
    output dispatch_pkg::raw_info_t                  raw
);

    import dispatch_pkg::*;

    always_comb begin
        vreg_idx_t [2:0] src_idx;
        logic      [2:0] src_used;
        logic      [2:0] haz;
        logic      [2:0] hit;
        vdata_t    [2:0] data;

        // Source order is vs1, vs2, vs3
        src_idx  = {uop.vd_idx, uop.vs2_idx, uop.vs1_idx};
        src_used = {uop.vs3_valid, uop.vs2_valid, uop.vs1_valid};
        haz      = '0;
        hit      = '0;
        data     = '0;

        // Entry 0 is oldest, so a later match is younger and wins
        for (int i = 0; i < ROB_DEPTH; i++) begin
            for (int s = 0; s < 3; s++) begin
                if (rob_entries[i].valid && src_used[s] &&
                    rob_entries[i].w_idx == src_idx[s]) begin
                    haz[s]  = !rob_entries[i].w_valid;
                    hit[s]  = rob_entries[i].w_valid;
                    data[s] = rob_entries[i].w_data;
                end
            end
        end

        raw.vs1_hazard = haz[0];
        raw.vs1_hit    = hit[0];
        raw.vs1_data   = data[0];
        raw.vs2_hazard = haz[1];
        raw.vs2_hit    = hit[1];
        raw.vs2_data   = data[1];
        raw.vs3_hazard = haz[2];
        raw.vs3_hit    = hit[2];
        raw.vs3_data   = data[2];
        // Any pending producer stalls the whole uop
        raw.hazard     = |haz;
    end

endmodule

// ==== hdl/dispatch_vrf_plan.sv ====
// VRF read planner that packs the sources of both uops onto the read ports
`timescale 1ns/1ps

module dispatch_vrf_plan (
    input  dispatch_pkg::dp_uop_t   [dispatch_pkg::NUM_DP_UOP-1:0] uop,
    output dispatch_pkg::vreg_idx_t [dispatch_pkg::NUM_VRF_RD-1:0] vrf_rd_idx,
    output logic                                                   strct_hazard
);

    import dispatch_pkg::*;

    src_cnt_t total_src;

    // Structural limit over all examined uops
    always_comb begin
        total_src = '0;
        for (int i = 0; i < NUM_DP_UOP; i++) begin
            total_src = total_src + src_count(uop[i]);
        end
    end

    assign strct_hazard = total_src > NUM_VRF_RD;

    // Ports are filled in uop order, then vs1, vs2, vs3 within a uop
    always_comb begin
        vreg_idx_t [2:0] src_idx;
        logic      [2:0] src_used;
        src_cnt_t        port;

        vrf_rd_idx = '0;
        port       = '0;
        for (int i = 0; i < NUM_DP_UOP; i++) begin
            src_idx  = {uop[i].vd_idx, uop[i].vs2_idx, uop[i].vs1_idx};
            src_used = {uop[i].vs3_valid, uop[i].vs2_valid, uop[i].vs1_valid};
            for (int s = 0; s < 3; s++) begin
                if (src_used[s]) begin
                    // Sources past the last port are not read since the uop cannot issue
                    if (port < NUM_VRF_RD) begin
                        vrf_rd_idx[port] = src_idx[s];
                    end
                    port = port + 1'b1;
                end
            end
        end
    end

endmodule

// ==== hdl/dispatch_operand_sel.sv ====
// Operand select for one uop between ROB bypass data and VRF read data
`timescale 1ns/1ps

module dispatch_operand_sel (
    input  dispatch_pkg::dp_uop_t                                uop,
    input  dispatch_pkg::raw_info_t                              raw,
    input  dispatch_pkg::vdata_t [dispatch_pkg::NUM_VRF_RD-1:0]  vrf_rd_data,
    input  dispatch_pkg::src_cnt_t                               slot_base,
    output dispatch_pkg::uop_operand_t                           operand
);

    import dispatch_pkg::*;

    function automatic vdata_t vrf_pick(src_cnt_t p);
        return (p < NUM_VRF_RD) ? vrf_rd_data[p] : '0;
    endfunction

    // Port numbering follows the planner, counted from this uop's first port
    always_comb begin
        src_cnt_t port;

        operand = '0;
        port    = slot_base;

        if (uop.vs1_valid) begin
            operand.vs1 = raw.vs1_hit ? raw.vs1_data : vrf_pick(port);
            port        = port + 1'b1;
        end

        if (uop.vs2_valid) begin
            operand.vs2 = raw.vs2_hit ? raw.vs2_data : vrf_pick(port);
            port        = port + 1'b1;
        end

        // vd read as vs3, the last source of the uop
        if (uop.vs3_valid) begin
            operand.vd = raw.vs3_hit ? raw.vs3_data : vrf_pick(port);
        end
    end

endmodule

// ==== hdl/dispatch_issue_ctrl.sv ====
// In-order issue control with queue, RS and ROB handshakes and the uop0 to uop1 RAW check
`timescale 1ns/1ps

module dispatch_issue_ctrl (
    input  logic                 [dispatch_pkg::NUM_DP_UOP-1:0] uop_valid,
    input  dispatch_pkg::dp_uop_t [dispatch_pkg::NUM_DP_UOP-1:0] uop,
    input  logic                 [dispatch_pkg::NUM_DP_UOP-1:0] raw_hazard,
    input  logic                                                strct_hazard,
    input  logic                 [dispatch_pkg::NUM_DP_UOP-1:0] alu_ready,
    input  logic                 [dispatch_pkg::NUM_DP_UOP-1:0] mul_ready,
    input  logic                 [dispatch_pkg::NUM_DP_UOP-1:0] rob_ready,
    output logic                 [dispatch_pkg::NUM_DP_UOP-1:0] uop_ready,
    output logic                 [dispatch_pkg::NUM_DP_UOP-1:0] alu_valid,
    output logic                 [dispatch_pkg::NUM_DP_UOP-1:0] mul_valid,
    output logic                 [dispatch_pkg::NUM_DP_UOP-1:0] rob_valid
);

    import dispatch_pkg::*;

    logic [NUM_DP_UOP-1:0] unit_ready;
    logic [NUM_DP_UOP-1:0] slot_ok;
    logic [NUM_DP_UOP-1:0] issue;
    logic                  uu_hazard;

    // True when u reads register r as any of its sources
    function automatic logic reads_reg(dp_uop_t u, vreg_idx_t r);
        logic rd1;
        logic rd2;
        logic rd3;

        rd1 = u.vs1_valid && u.vs1_idx == r;
        rd2 = u.vs2_valid && u.vs2_idx == r;
        rd3 = u.vs3_valid && u.vd_idx == r;
        return rd1 || rd2 || rd3;
    endfunction

    // Ready of the RS that the uop targets
    always_comb begin
        for (int i = 0; i < NUM_DP_UOP; i++) begin
            unit_ready[i] = (uop[i].exe_unit == EXE_ALU) ? alu_ready[i] : mul_ready[i];
        end
    end

    // uop1 must not read what uop0 is about to write
    assign uu_hazard = uop[0].vd_valid && reads_reg(uop[1], uop[0].vd_idx);

    // Per-slot conditions that do not depend on the older slot
    always_comb begin
        for (int i = 0; i < NUM_DP_UOP; i++) begin
            slot_ok[i] = uop_valid[i] && !raw_hazard[i] && unit_ready[i] && rob_ready[i];
        end
    end

    // In order, slot 1 only follows slot 0
    assign issue[0] = slot_ok[0];
    assign issue[1] = issue[0] && slot_ok[1] && !strct_hazard && !uu_hazard;

    assign uop_ready = issue;
    assign rob_valid = issue;

    always_comb begin
        for (int i = 0; i < NUM_DP_UOP; i++) begin
            alu_valid[i] = issue[i] && uop[i].exe_unit == EXE_ALU;
            mul_valid[i] = issue[i] && uop[i].exe_unit == EXE_MUL;
        end
    end

endmodule

// ==== hdl/rvv_dispatch.sv ====
// RVV dispatch stage top level with VRF planning, RAW checks, operand bypass and issue
`timescale 1ns/1ps

module rvv_dispatch #(
    parameter int ROB_DEPTH = dispatch_pkg::ROB_DEPTH
) (
    input  logic                                                    clk,
    input  logic                                                    rst_n,
    // Uop queue
    input  logic                  [dispatch_pkg::NUM_DP_UOP-1:0]    uop_valid,
    input  dispatch_pkg::dp_uop_t [dispatch_pkg::NUM_DP_UOP-1:0]    uop,
    output logic                  [dispatch_pkg::NUM_DP_UOP-1:0]    uop_ready,
    // ALU reservation station
    output logic                  [dispatch_pkg::NUM_DP_UOP-1:0]    alu_valid,
    output dispatch_pkg::rs_uop_t [dispatch_pkg::NUM_DP_UOP-1:0]    alu_uop,
    input  logic                  [dispatch_pkg::NUM_DP_UOP-1:0]    alu_ready,
    // MUL reservation station
    output logic                  [dispatch_pkg::NUM_DP_UOP-1:0]    mul_valid,
    output dispatch_pkg::rs_uop_t [dispatch_pkg::NUM_DP_UOP-1:0]    mul_uop,
    input  logic                  [dispatch_pkg::NUM_DP_UOP-1:0]    mul_ready,
    // ROB push
    output logic                    [dispatch_pkg::NUM_DP_UOP-1:0]  rob_valid,
    output dispatch_pkg::rob_push_t [dispatch_pkg::NUM_DP_UOP-1:0]  rob_push,
    input  logic                    [dispatch_pkg::NUM_DP_UOP-1:0]  rob_ready,
    input  dispatch_pkg::rob_tag_t                                  rob_tag_base,
    // VRF read with data returning in the same cycle
    output dispatch_pkg::vreg_idx_t [dispatch_pkg::NUM_VRF_RD-1:0]  vrf_rd_idx,
    input  dispatch_pkg::vdata_t    [dispatch_pkg::NUM_VRF_RD-1:0]  vrf_rd_data,
    // ROB state with the oldest entry at index 0
    input  dispatch_pkg::rob_entry_t [ROB_DEPTH-1:0]                rob_entries
);

    import dispatch_pkg::*;

    raw_info_t    [NUM_DP_UOP-1:0] raw;
    uop_operand_t [NUM_DP_UOP-1:0] operand;
    src_cnt_t     [NUM_DP_UOP-1:0] slot_base;
    logic         [NUM_DP_UOP-1:0] raw_hazard;
    rs_uop_t      [NUM_DP_UOP-1:0] rs_uop;
    logic                          strct_hazard;

    dispatch_vrf_plan u_vrf_plan (
        .uop          (uop),
        .vrf_rd_idx   (vrf_rd_idx),
        .strct_hazard (strct_hazard)
    );

    // uop0 always starts at VRF port 0
    assign slot_base[0] = '0;

    genvar i;
    generate
        for (i = 1; i < NUM_DP_UOP; i++) begin : gen_base
            assign slot_base[i] = slot_base[i-1] + src_count(uop[i-1]);
        end

        for (i = 0; i < NUM_DP_UOP; i++) begin : gen_slot
            dispatch_raw_rob #(
                .ROB_DEPTH (ROB_DEPTH)
            ) u_raw_rob (
                .uop         (uop[i]),
                .rob_entries (rob_entries),
                .raw         (raw[i])
            );

            dispatch_operand_sel u_operand_sel (
                .uop         (uop[i]),
                .raw         (raw[i]),
                .vrf_rd_data (vrf_rd_data),
                .slot_base   (slot_base[i]),
                .operand     (operand[i])
            );

            assign raw_hazard[i] = raw[i].hazard;

            // Tag wraps with the ROB pointer
            assign rs_uop[i].rob_tag   = rob_tag_t'(rob_tag_base + i);
            assign rs_uop[i].funct6    = uop[i].funct6;
            assign rs_uop[i].vs1_data  = operand[i].vs1;
            assign rs_uop[i].vs1_valid = uop[i].vs1_valid;
            assign rs_uop[i].vs2_data  = operand[i].vs2;
            assign rs_uop[i].vs2_valid = uop[i].vs2_valid;
            assign rs_uop[i].vd_data   = operand[i].vd;
            assign rs_uop[i].vd_valid  = uop[i].vs3_valid;
            assign rs_uop[i].rs1_data  = uop[i].rs1_data;
            assign rs_uop[i].rs1_valid = uop[i].rs1_valid;

            // Both RS ports see the same payload and the valid selects the unit
            assign alu_uop[i] = rs_uop[i];
            assign mul_uop[i] = rs_uop[i];

            assign rob_push[i].w_idx    = uop[i].vd_idx;
            assign rob_push[i].w_valid  = uop[i].vd_valid;
            assign rob_push[i].last_uop = uop[i].last_uop;
        end
    endgenerate

    dispatch_issue_ctrl u_issue_ctrl (
        .uop_valid    (uop_valid),
        .uop          (uop),
        .raw_hazard   (raw_hazard),
        .strct_hazard (strct_hazard),
        .alu_ready    (alu_ready),
        .mul_ready    (mul_ready),
        .rob_ready    (rob_ready),
        .uop_ready    (uop_ready),
        .alu_valid    (alu_valid),
        .mul_valid    (mul_valid),
        .rob_valid    (rob_valid)
    );

endmodule

// ==== bench/dispatch_props.sv ====
// Handshake properties of the dispatch stage, sampled on the rising clock edge
`timescale 1ns/1ps

module dispatch_props (
    input logic                                clk,
    input logic                                rst_n,
    input logic [dispatch_pkg::NUM_DP_UOP-1:0] uop_ready,
    input logic [dispatch_pkg::NUM_DP_UOP-1:0] alu_valid,
    input logic [dispatch_pkg::NUM_DP_UOP-1:0] mul_valid,
    input logic [dispatch_pkg::NUM_DP_UOP-1:0] rob_valid
);

    int fail_count = 0;

    // Slot 1 never leaves the queue ahead of slot 0
    assert property (@(posedge clk) disable iff (!rst_n) uop_ready[1] |-> uop_ready[0])
    else begin
        fail_count++;
        $error("slot 1 ready while slot 0 is not ready");
    end

    // Queue is held empty in reset so nothing may be offered downstream
    assert property (@(posedge clk) !rst_n |-> !(|{uop_ready, alu_valid, mul_valid, rob_valid}))
    else begin
        fail_count++;
        $error("valid or ready output high during reset");
    end

endmodule

bind rvv_dispatch dispatch_props u_props (
    .clk       (clk),
    .rst_n     (rst_n),
    .uop_ready (uop_ready),
    .alu_valid (alu_valid),
    .mul_valid (mul_valid),
    .rob_valid (rob_valid)
);

// ==== bench/tb_clk_gen.sv ====
// Clock and reset source for the dispatch testbench
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS  = 20,
    parameter int RST_CYCLES = 4
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Reset held low for a fixed number of rising edges
    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// ==== bench/tb_rvv_dispatch.sv ====
// Testbench for the RVV dispatch stage with random uops, ROB state and back-pressure
`timescale 1ns/1ps

module tb_rvv_dispatch;

    import dispatch_pkg::*;

    localparam int PERIOD_NS     = 20;
    localparam int RST_CYCLES    = 4;
    localparam int NUM_CYCLES    = 600;
    localparam int MARGIN_CYCLES = 20;

    logic clk;
    logic rst_n;

    logic       [NUM_DP_UOP-1:0] uop_valid;
    dp_uop_t    [NUM_DP_UOP-1:0] uop;
    logic       [NUM_DP_UOP-1:0] uop_ready;
    logic       [NUM_DP_UOP-1:0] alu_valid;
    rs_uop_t    [NUM_DP_UOP-1:0] alu_uop;
    logic       [NUM_DP_UOP-1:0] alu_ready;
    logic       [NUM_DP_UOP-1:0] mul_valid;
    rs_uop_t    [NUM_DP_UOP-1:0] mul_uop;
    logic       [NUM_DP_UOP-1:0] mul_ready;
    logic       [NUM_DP_UOP-1:0] rob_valid;
    rob_push_t  [NUM_DP_UOP-1:0] rob_push;
    logic       [NUM_DP_UOP-1:0] rob_ready;
    rob_tag_t                    rob_tag_base;
    vreg_idx_t  [NUM_VRF_RD-1:0] vrf_rd_idx;
    vdata_t     [NUM_VRF_RD-1:0] vrf_rd_data;
    rob_entry_t [ROB_DEPTH-1:0]  rob_entries;

    vdata_t vrf_mem [32];
    integer seed;
    int     check_errors;
    int     cycle;

    tb_clk_gen #(
        .PERIOD_NS  (PERIOD_NS),
        .RST_CYCLES (RST_CYCLES)
    ) u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    rvv_dispatch #(
        .ROB_DEPTH (ROB_DEPTH)
    ) dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .uop_valid    (uop_valid),
        .uop          (uop),
        .uop_ready    (uop_ready),
        .alu_valid    (alu_valid),
        .alu_uop      (alu_uop),
        .alu_ready    (alu_ready),
        .mul_valid    (mul_valid),
        .mul_uop      (mul_uop),
        .mul_ready    (mul_ready),
        .rob_valid    (rob_valid),
        .rob_push     (rob_push),
        .rob_ready    (rob_ready),
        .rob_tag_base (rob_tag_base),
        .vrf_rd_idx   (vrf_rd_idx),
        .vrf_rd_data  (vrf_rd_data),
        .rob_entries  (rob_entries)
    );

    // VRF model answers in the same cycle
    always_comb begin
        for (int p = 0; p < NUM_VRF_RD; p++) begin
            vrf_rd_data[p] = vrf_mem[vrf_rd_idx[p]];
        end
    end

    task automatic compare(input string name, input logic [511:0] expected,
                           input logic [511:0] actual);
        assert (actual === expected)
        else begin
            check_errors++;
            $display("Fail %s cycle %0d expected %0h actual %0h", name, cycle, expected, actual);
        end
    endtask

    // Status of the youngest valid ROB entry writing r is 0 for none, 1 for ready, 2 for pending
    function automatic int rob_lookup(input vreg_idx_t r, output vdata_t d);
        d = '0;
        for (int e = ROB_DEPTH - 1; e >= 0; e--) begin
            if (rob_entries[e].valid && rob_entries[e].w_idx == r) begin
                d = rob_entries[e].w_data;
                return rob_entries[e].w_valid ? 1 : 2;
            end
        end
        return 0;
    endfunction

    task automatic drive_random();
        logic [63:0] r;

        for (int i = 0; i < NUM_DP_UOP; i++) begin
            r = {$random(seed), $random(seed)};
            uop[i] = r[$bits(dp_uop_t)-1:0];
            // Only eight registers are used so that sources collide often with the ROB and the other uop
            uop[i].vs1_idx[4:3] = '0;
            uop[i].vs2_idx[4:3] = '0;
            uop[i].vd_idx[4:3]  = '0;
            uop_valid[i] = ($random(seed) & 7) != 0;
            alu_ready[i] = ($random(seed) & 7) != 0;
            mul_ready[i] = ($random(seed) & 7) != 0;
            rob_ready[i] = ($random(seed) & 7) != 0;
        end
        rob_tag_base = rob_tag_t'($random(seed));
        for (int e = 0; e < ROB_DEPTH; e++) begin
            rob_entries[e].valid   = ($random(seed) & 1) != 0;
            rob_entries[e].w_idx   = vreg_idx_t'($random(seed) & 7);
            rob_entries[e].w_valid = ($random(seed) & 3) != 0;
            rob_entries[e].w_data  = {$random(seed), $random(seed), $random(seed), $random(seed)};
        end
    endtask

    task automatic check_outputs();
        vreg_idx_t [NUM_VRF_RD-1:0] exp_rd;
        rs_uop_t   [NUM_DP_UOP-1:0] exp_rs;
        logic      [NUM_DP_UOP-1:0] haz;
        logic      [NUM_DP_UOP-1:0] unit_rdy;
        logic      [NUM_DP_UOP-1:0] exp_issue;
        logic      [NUM_DP_UOP-1:0] exp_alu;
        vreg_idx_t [2:0]            idx;
        logic      [2:0]            used;
        vdata_t    [2:0]            opnd;
        vdata_t                     d;
        rs_uop_t                    act_rs;
        rob_push_t                  exp_push;
        int                         port;
        int                         st;
        logic                       rd_vd;

        exp_rd = '0;
        port   = 0;
        for (int i = 0; i < NUM_DP_UOP; i++) begin
            idx    = {uop[i].vd_idx, uop[i].vs2_idx, uop[i].vs1_idx};
            used   = {uop[i].vs3_valid, uop[i].vs2_valid, uop[i].vs1_valid};
            haz[i] = 1'b0;
            opnd   = '0;
            for (int s = 0; s < 3; s++) begin
                if (used[s]) begin
                    st      = rob_lookup(idx[s], d);
                    haz[i]  = haz[i] || st == 2;
                    opnd[s] = (st == 1) ? d : vrf_mem[idx[s]];
                    if (port < NUM_VRF_RD) begin
                        exp_rd[port] = idx[s];
                    end
                    port++;
                end
            end
            exp_rs[i] = '{rob_tag: rob_tag_t'((int'(rob_tag_base) + i) % ROB_DEPTH),
                          funct6: uop[i].funct6,
                          vs1_data: opnd[0], vs1_valid: uop[i].vs1_valid,
                          vs2_data: opnd[1], vs2_valid: uop[i].vs2_valid,
                          vd_data: opnd[2], vd_valid: uop[i].vs3_valid,
                          rs1_data: uop[i].rs1_data, rs1_valid: uop[i].rs1_valid};
            unit_rdy[i] = (uop[i].exe_unit == EXE_ALU) ? alu_ready[i] : mul_ready[i];
        end

        rd_vd = (uop[1].vs1_valid && uop[1].vs1_idx == uop[0].vd_idx)
             || (uop[1].vs2_valid && uop[1].vs2_idx == uop[0].vd_idx)
             || (uop[1].vs3_valid && uop[1].vd_idx == uop[0].vd_idx);
        exp_issue[0] = uop_valid[0] && !haz[0] && unit_rdy[0] && rob_ready[0];
        exp_issue[1] = exp_issue[0] && uop_valid[1] && !haz[1] && port <= NUM_VRF_RD
                    && !(uop[0].vd_valid && rd_vd) && unit_rdy[1] && rob_ready[1];
        for (int i = 0; i < NUM_DP_UOP; i++) begin
            exp_alu[i] = exp_issue[i] && uop[i].exe_unit == EXE_ALU;
        end

        compare("uop_ready", exp_issue, uop_ready);
        compare("rob_valid", exp_issue, rob_valid);
        compare("alu_valid", exp_alu, alu_valid);
        compare("mul_valid", exp_issue & ~exp_alu, mul_valid);
        compare("vrf_rd_idx", exp_rd, vrf_rd_idx);

        // Payloads only matter for slots that issue
        for (int i = 0; i < NUM_DP_UOP; i++) begin
            if (exp_issue[i]) begin
                act_rs   = exp_alu[i] ? alu_uop[i] : mul_uop[i];
                exp_push = '{w_idx: uop[i].vd_idx, w_valid: uop[i].vd_valid,
                             last_uop: uop[i].last_uop};
                compare($sformatf("rs_uop slot %0d", i), exp_rs[i], act_rs);
                compare($sformatf("rob_push slot %0d", i), exp_push, rob_push[i]);
            end
        end
    endtask

    initial begin
        seed         = 32'h5a1e7070;
        check_errors = 0;
        cycle        = 0;
        uop_valid    = '0;
        uop          = '0;
        alu_ready    = '0;
        mul_ready    = '0;
        rob_ready    = '0;
        rob_tag_base = '0;
        rob_entries  = '0;
        for (int a = 0; a < 32; a++) begin
            vrf_mem[a] = {$random(seed), $random(seed), $random(seed), $random(seed)};
        end

        wait (rst_n);
        repeat (NUM_CYCLES) begin
            @(posedge clk);
            #2;
            drive_random();
            #8;
            check_outputs();
            cycle++;
        end
        // One more edge so the bound properties see the last cycle
        @(posedge clk);
        $display("Errors: %0d value checks, %0d properties",
                 check_errors, dut.u_props.fail_count);
        if (check_errors == 0 && dut.u_props.fail_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Watchdog sized from the reset, the test cycles and a small margin
    initial begin
        #((RST_CYCLES + NUM_CYCLES + MARGIN_CYCLES) * PERIOD_NS);
        $display("Watchdog expired before the test cycles completed");
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== flist.f ====
hdl/dispatch_pkg.sv
hdl/dispatch_raw_rob.sv
hdl/dispatch_vrf_plan.sv
hdl/dispatch_operand_sel.sv
hdl/dispatch_issue_ctrl.sv
hdl/rvv_dispatch.sv
bench/dispatch_props.sv
bench/tb_clk_gen.sv
bench/tb_rvv_dispatch.sv
